//--- run.sh
#!/bin/sh
# Compile with Verilator and run the immediate decode testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_imm_decode \
	-f tb.f -o sim_imm_decode
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/sim_imm_decode > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
exit 0

//--- source/fetch_counter.sv
/*
 * Fetch address register and remaining word counter
 */
`timescale 1ns/100ps

module fetch_counter
#(
	parameter int addr_width  = 32,
	parameter int count_width = 16,
	parameter int addr_step   = 8
)
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   load,
	input  logic                   step,
	input  logic [addr_width-1:0]  start_addr,
	input  logic [count_width-1:0] word_count,
	output logic [addr_width-1:0]  addr,
	output logic                   last
);

	logic [count_width-1:0] count;

	// Load takes a new run, each step moves on by one instruction word
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			addr  <= '0;
			count <= '0;
		end
		else if (load)
		begin
			addr  <= start_addr;
			count <= word_count;
		end
		else if (step)
		begin
			addr  <= addr + addr_width'(addr_step);
			count <= count - 1'b1;
		end
	end

	// The word now being fetched is the final one of the run
	assign last = (count == count_width'(1));

endmodule

//--- source/fetch_fsm.sv
/*
 * Fetch sequencer
 * Runs one Wishbone classic read per word, hands the word to the decoder
 * and holds the output stream until the record is accepted
 */
`timescale 1ns/100ps

module fetch_fsm
	import imm_decode_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         start,
	input  logic         last,
	input  logic         wb_ack,
	input  logic [63:0]  wb_dat_i,
	input  logic         is_prefix,
	input  logic         rec_ready,
	output logic         wb_cyc,
	output logic         wb_stb,
	output logic         load,
	output logic         step,
	output logic         clear,
	output logic         merge_en,
	output instruction_t word,
	output logic         rec_valid,
	output logic         done
);

	fetch_state_e state;
	fetch_state_e state_nxt;
	logic         leave_word;

	// ======================================================================
	// Next state
	// ======================================================================

	always_comb
	begin
		state_nxt = state;
		case (state)
		IDLE:
			if (start)
				state_nxt = REQ;
		// Bus cycle stays open until the slave acknowledges
		REQ:
			if (wb_ack)
				state_nxt = DECODE;
		// Prefixes never reach the output stream
		DECODE:
			if (!is_prefix)
				state_nxt = OUTPUT;
			else if (last)
				state_nxt = IDLE;
			else
				state_nxt = REQ;
		// Back-pressure holds the record, no new read is issued meanwhile
		OUTPUT:
			if (rec_ready)
				state_nxt = last ? IDLE : REQ;
		default:
			state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// ======================================================================
	// Outputs
	// ======================================================================

	// A word is finished when its prefix is absorbed or its record is taken
	assign leave_word = (state == DECODE && is_prefix) || (state == OUTPUT && rec_ready);

	assign wb_cyc    = (state == REQ);
	assign wb_stb    = (state == REQ);
	assign load      = (state == IDLE) && start;
	assign clear     = (state == IDLE) && start;
	assign merge_en  = (state == DECODE);
	assign rec_valid = (state == OUTPUT);
	assign step      = leave_word;

	// Read data is only valid on the acknowledge cycle
	always_ff @(posedge clk)
	begin
		if (state == REQ && wb_ack)
			word.raw <= wb_dat_i;
	end

	// One cycle pulse after the final word of the run is consumed
	always_ff @(posedge clk)
	begin
		if (reset)
			done <= 1'b0;
		else
			done <= leave_word && last;
	end

endmodule

//--- source/fp32_to_fp64.sv
/*
 * Single to double precision conversion of a float immediate
 * Denormals flush to a signed zero, infinities and NaNs are kept
 */
`timescale 1ns/100ps

module fp32_to_fp64
	import imm_decode_pkg::*;
(
	input  logic [31:0] sp,
	output value_t      dp
);

	// Difference between the double bias 1023 and the single bias 127
	localparam logic [10:0] bias_diff = 11'd896;

	logic        sign;
	logic [7:0]  exp_sp;
	logic [22:0] man_sp;

	assign sign   = sp[31];
	assign exp_sp = sp[30:23];
	assign man_sp = sp[22:0];

	always_comb
	begin
		// Zero and denormal inputs both give a zero that keeps its sign
		if (exp_sp == 8'h00)
			dp = {sign, 63'd0};
		// All ones stays all ones, the payload of a NaN moves to the top
		else if (exp_sp == 8'hff)
			dp = {sign, 11'h7ff, man_sp, 29'd0};
		// Normal numbers only need the exponent re-biased
		else
			dp = {sign, {3'b000, exp_sp} + bias_diff, man_sp, 29'd0};
	end

endmodule

//--- source/imm_decode_pkg.sv
/*
 * Shared types for the instruction fetch and immediate decode front end
 * Opcode encoding, named views of the instruction word, decoded record,
 * operand value type and the fetch FSM state encoding
 */
package imm_decode_pkg;

	// Operand width of the CPU
	typedef logic [63:0] value_t;

	localparam value_t value_zero = 64'd0;

	// ======================================================================
	// Opcodes
	// ======================================================================

	// Seven bit major opcode held in the low bits of every word
	typedef enum logic [6:0]
	{
		OP_NOP    = 7'h00,
		OP_ADDI   = 7'h04,
		OP_ANDI   = 7'h08,
		OP_ORI    = 7'h09,
		OP_SHIFT  = 7'h10,
		OP_FADDI  = 7'h14,
		OP_BCC    = 7'h28,
		OP_LDX    = 7'h40,
		OP_STX    = 7'h50,
		OP_PFXAB  = 7'h7c,
		OP_PFXC   = 7'h7d
	} opcode_e;

	// ======================================================================
	// Instruction word views
	// ======================================================================

	// Any format, only the opcode is of interest
	typedef struct packed
	{
		logic [56:0] rsv;
		opcode_e     opcode;
	} ins_any_t;

	// Thirty-two bit immediate in the upper half (ADDI, ANDI, ORI, FADDI)
	typedef struct packed
	{
		logic [31:0] imm32;
		logic [24:0] rsv;
		opcode_e     opcode;
	} ins_imm_t;

	// Load and store with a 24 bit displacement
	typedef struct packed
	{
		logic [23:0] disp24;
		logic [32:0] rsv;
		opcode_e     opcode;
	} ins_ls_t;

	// Conditional branch with a 20 bit displacement
	typedef struct packed
	{
		logic [19:0] br_disp;
		logic [36:0] rsv;
		opcode_e     opcode;
	} ins_br_t;

	// Shift amount, sh_i tells whether it is an immediate at all
	typedef struct packed
	{
		logic [49:0] rsv;
		logic [5:0]  sh_imm;
		logic        sh_i;
		opcode_e     opcode;
	} ins_sh_t;

	// Prefix word carrying the upper 56 bits of an operand
	typedef struct packed
	{
		logic [55:0] pfx_imm;
		logic        pfx_sw;
		opcode_e     opcode;
	} ins_pfx_t;

	typedef union packed
	{
		logic [63:0] raw;
		ins_any_t    any;
		ins_imm_t    imm;
		ins_ls_t     ls;
		ins_br_t     br;
		ins_sh_t     sh;
		ins_pfx_t    pfx;
	} instruction_t;

	// ======================================================================
	// Decoded record and fetch state
	// ======================================================================

	// Three immediate slots with their has and prefix flags, 198 bits
	typedef struct packed
	{
		value_t imma;
		value_t immb;
		value_t immc;
		logic   has_imma;
		logic   has_immb;
		logic   has_immc;
		logic   pfxa;
		logic   pfxb;
		logic   pfxc;
	} imm_rec_t;

	typedef enum logic [1:0]
	{
		IDLE,
		REQ,
		DECODE,
		OUTPUT
	} fetch_state_e;

endpackage

//--- source/imm_decode_top.sv
/*
 * Instruction fetch and immediate decode front end
 * Wishbone classic read master, per-word immediate decode, prefix folding
 * and a valid/ready record stream
 */
`timescale 1ns/100ps

module imm_decode_top
	import imm_decode_pkg::*;
#(
	parameter int addr_width  = 32,
	parameter int count_width = 16,
	parameter int addr_step   = 8
)
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   start,
	input  logic [addr_width-1:0]  start_addr,
	input  logic [count_width-1:0] word_count,
	output logic                   wb_cyc,
	output logic                   wb_stb,
	output logic [addr_width-1:0]  wb_adr,
	input  logic [63:0]            wb_dat_i,
	input  logic                   wb_ack,
	output imm_rec_t               rec,
	output logic                   rec_valid,
	input  logic                   rec_ready,
	output logic                   done
);

	logic         last;
	logic         load;
	logic         step;
	logic         clear;
	logic         merge_en;
	logic         is_prefix;
	instruction_t word;
	imm_rec_t     dec;

	// Sequencer for bus reads and the output handshake
	fetch_fsm u_fetch_fsm
	(
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.last      (last),
		.wb_ack    (wb_ack),
		.wb_dat_i  (wb_dat_i),
		.is_prefix (is_prefix),
		.rec_ready (rec_ready),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.load      (load),
		.step      (step),
		.clear     (clear),
		.merge_en  (merge_en),
		.word      (word),
		.rec_valid (rec_valid),
		.done      (done)
	);

	// The counter address drives the bus directly
	fetch_counter
	#(
		.addr_width  (addr_width),
		.count_width (count_width),
		.addr_step   (addr_step)
	)
	u_fetch_counter
	(
		.clk        (clk),
		.reset      (reset),
		.load       (load),
		.step       (step),
		.start_addr (start_addr),
		.word_count (word_count),
		.addr       (wb_adr),
		.last       (last)
	);

	imm_decoder u_imm_decoder
	(
		.ins       (word),
		.imm       (dec),
		.is_prefix (is_prefix)
	);

	prefix_merge u_prefix_merge
	(
		.clk       (clk),
		.reset     (reset),
		.clear     (clear),
		.merge_en  (merge_en),
		.is_prefix (is_prefix),
		.dec       (dec),
		.rec       (rec)
	);

endmodule

//--- source/imm_decoder.sv
/*
 * Immediate operand decoder
 * Extracts the a, b and c immediates of one instruction word by opcode,
 * with has flags, prefix flags and a prefix indication
 */
`timescale 1ns/100ps

module imm_decoder
	import imm_decode_pkg::*;
(
	input  instruction_t ins,
	output imm_rec_t     imm,
	output logic         is_prefix
);

	// Double precision form of the 32 bit immediate field
	value_t fimm;

	// The converter always looks at imm32, only FADDI takes its result
	fp32_to_fp64 u_cvt
	(
		.sp (ins.imm.imm32),
		.dp (fimm)
	);

	always_comb
	begin
		// Every slot starts empty so unused opcodes give an all zero record
		imm.imma     = value_zero;
		imm.immb     = value_zero;
		imm.immc     = value_zero;
		imm.has_imma = 1'b0;
		imm.has_immb = 1'b0;
		imm.has_immc = 1'b0;
		imm.pfxa     = 1'b0;
		imm.pfxb     = 1'b0;
		imm.pfxc     = 1'b0;
		is_prefix    = 1'b0;

		case (ins.any.opcode)
		// Arithmetic immediate is signed
		OP_ADDI:
			begin
				imm.immb     = {{32{ins.imm.imm32[31]}}, ins.imm.imm32};
				imm.has_immb = 1'b1;
			end
		// AND keeps the upper bits of the register by filling with ones
		OP_ANDI:
			begin
				imm.immb     = {{32{1'b1}}, ins.imm.imm32};
				imm.has_immb = 1'b1;
			end
		// OR leaves the upper bits alone, so fill with zeros
		OP_ORI:
			begin
				imm.immb     = {32'd0, ins.imm.imm32};
				imm.has_immb = 1'b1;
			end
		// Memory displacements are signed byte offsets
		OP_LDX,
		OP_STX:
			begin
				imm.immb     = {{40{ins.ls.disp24[23]}}, ins.ls.disp24};
				imm.has_immb = 1'b1;
			end
		// Branch target displacement goes in the c slot
		OP_BCC:
			begin
				imm.immc     = {{44{ins.br.br_disp[19]}}, ins.br.br_disp};
				imm.has_immc = 1'b1;
			end
		// A shift by register still decodes the field, but without a has flag
		OP_SHIFT:
			begin
				imm.immc     = {58'd0, ins.sh.sh_imm};
				imm.has_immc = ins.sh.sh_i;
			end
		OP_FADDI:
			begin
				imm.immb     = fimm;
				imm.has_immb = 1'b1;
			end
		// The sw bit picks b over a as the target of the prefix
		OP_PFXAB:
			begin
				is_prefix = 1'b1;
				if (ins.pfx.pfx_sw)
				begin
					imm.immb     = {ins.pfx.pfx_imm, 8'h00};
					imm.has_immb = 1'b1;
					imm.pfxb     = 1'b1;
				end
				else
				begin
					imm.imma     = {ins.pfx.pfx_imm, 8'h00};
					imm.has_imma = 1'b1;
					imm.pfxa     = 1'b1;
				end
			end
		OP_PFXC:
			begin
				is_prefix    = 1'b1;
				imm.immc     = {ins.pfx.pfx_imm, 8'h00};
				imm.has_immc = 1'b1;
				imm.pfxc     = 1'b1;
			end
		default:
			begin
				// NOP and unknown opcodes carry no immediate
			end
		endcase
	end

endmodule

//--- source/prefix_merge.sv
/*
 * Prefix merge stage
 * Holds the pending prefix value of each slot and folds it into the
 * next ordinary instruction, then registers the finished record
 */
`timescale 1ns/100ps

module prefix_merge
	import imm_decode_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     clear,
	input  logic     merge_en,
	input  logic     is_prefix,
	input  imm_rec_t dec,
	output imm_rec_t rec
);

	// Slot index 0 is a, 1 is b, 2 is c
	value_t      dec_val [3];
	logic [2:0]  dec_has;
	logic [2:0]  dec_pfx;
	logic [55:0] pend_val [3];
	logic [2:0]  pend_vld;
	value_t      mrg_val [3];
	logic [2:0]  mrg_has;
	logic [2:0]  mrg_pfx;

	assign dec_val[0] = dec.imma;
	assign dec_val[1] = dec.immb;
	assign dec_val[2] = dec.immc;
	assign dec_has    = {dec.has_immc, dec.has_immb, dec.has_imma};
	assign dec_pfx    = {dec.pfxc, dec.pfxb, dec.pfxa};

	// A pending prefix supplies the upper 56 bits and the word keeps its low byte
	always_comb
	begin
		for (int i = 0; i < 3; i++)
		begin
			if (pend_vld[i])
				mrg_val[i] = {pend_val[i], dec_val[i][7:0]};
			else
				mrg_val[i] = dec_val[i];
			mrg_has[i] = dec_has[i] | pend_vld[i];
			mrg_pfx[i] = dec_pfx[i] | pend_vld[i];
		end
	end

	// Pending flags are set by prefixes and consumed by the next ordinary word
	always_ff @(posedge clk)
	begin
		if (reset)
			pend_vld <= 3'b000;
		else if (clear)
			pend_vld <= 3'b000;
		else if (merge_en)
		begin
			if (is_prefix)
				pend_vld <= pend_vld | dec_pfx;
			else
				pend_vld <= 3'b000;
		end
	end

	// A later prefix for the same slot overwrites the earlier value
	always_ff @(posedge clk)
	begin
		if (merge_en)
		begin
			if (is_prefix)
			begin
				for (int i = 0; i < 3; i++)
					if (dec_pfx[i])
						pend_val[i] <= dec_val[i][63:8];
			end
			else
			begin
				rec.imma     <= mrg_val[0];
				rec.immb     <= mrg_val[1];
				rec.immc     <= mrg_val[2];
				rec.has_imma <= mrg_has[0];
				rec.has_immb <= mrg_has[1];
				rec.has_immc <= mrg_has[2];
				rec.pfxa     <= mrg_pfx[0];
				rec.pfxb     <= mrg_pfx[1];
				rec.pfxc     <= mrg_pfx[2];
			end
		end
	end

endmodule

//--- tb.f
source/imm_decode_pkg.sv
source/fp32_to_fp64.sv
source/imm_decoder.sv
source/prefix_merge.sv
source/fetch_counter.sv
source/fetch_fsm.sv
source/imm_decode_top.sv
test/tb_imm_mem.sv
test/tb_imm_decode.sv

//--- test/tb_imm_decode.sv
/*
 * Testbench for the fetch and immediate decode front end
 * Stimulus table with expected records, run control, record and bus
 * monitors, random stalls and ack delays, checks and a watchdog
 */
`timescale 1ns/100ps

module tb_imm_decode
	import imm_decode_pkg::*;
();

	// One table row is a memory word and, for ordinary words, its record
	typedef struct packed
	{
		instruction_t word;
		logic         is_rec;
		imm_rec_t     exp;
	} entry_t;

	localparam int n_entries   = 29;
	localparam int n_runs      = 7;
	localparam int word_cycles = 40;
	localparam int run_margin  = 50;
	localparam logic [31:0] base_addr = 32'h0000_1000;

	// Each run fetches a slice of the table, run 4 repeats the first 25 rows
	localparam int run_first [n_runs] = '{0, 6, 10, 17, 0, 25, 28};
	localparam int run_count [n_runs] = '{6, 4, 7, 8, 25, 3, 1};

	logic        clk = 1'b0;
	logic        reset;
	logic        start;
	logic [31:0] start_addr;
	logic [15:0] word_count;
	logic        wb_cyc;
	logic        wb_stb;
	logic [31:0] wb_adr;
	logic [63:0] wb_dat_i;
	logic        wb_ack;
	imm_rec_t    rec;
	logic        rec_valid;
	logic        rec_ready = 1'b0;
	logic        done;
	logic [2:0]  ack_delay = 3'd0;

	entry_t      tbl [n_entries];
	int          n_tbl;
	imm_rec_t    exp_list [64];
	int          exp_src [64];
	int          exp_total;
	int          taken;
	int          done_cnt;
	int          left_at_done;
	int          rec_errors;
	int          run_errors;
	int          rec_checks;
	int          tests_passed;
	int          tests_failed;
	logic [31:0] exp_adr = 32'd0;
	logic        req_open = 1'b0;
	logic [31:0] lcg_state = 32'ha75f_1579;
	logic [31:0] rnd;

	always #50 clk = ~clk;

	imm_decode_top
	#(
		.addr_width  (32),
		.count_width (16),
		.addr_step   (8)
	)
	u_imm_decode_top
	(
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.start_addr (start_addr),
		.word_count (word_count),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_adr     (wb_adr),
		.wb_dat_i   (wb_dat_i),
		.wb_ack     (wb_ack),
		.rec        (rec),
		.rec_valid  (rec_valid),
		.rec_ready  (rec_ready),
		.done       (done)
	);

	tb_imm_mem #(.depth(64)) u_mem
	(
		.clk   (clk),
		.reset (reset),
		.cyc   (wb_cyc),
		.stb   (wb_stb),
		.adr   (wb_adr),
		.delay (ack_delay),
		.dat   (wb_dat_i),
		.ack   (wb_ack)
	);

	// ======================================================================
	// Word and record builders
	// ======================================================================

	// Upper 32 bits hold imm32
	function automatic instruction_t imm_word(opcode_e op, logic [31:0] v);
		instruction_t w;
		w.raw = {v, 25'd0, op};
		return w;
	endfunction

	function automatic instruction_t ls_word(opcode_e op, logic [23:0] d);
		instruction_t w;
		w.raw = {d, 33'd0, op};
		return w;
	endfunction

	function automatic instruction_t br_word(logic [19:0] d);
		instruction_t w;
		w.raw = {d, 37'd0, OP_BCC};
		return w;
	endfunction

	// Shift amount sits at 13..8 with its immediate flag at bit 7
	function automatic instruction_t sh_word(logic [5:0] amt, logic imm_flag);
		instruction_t w;
		w.raw = {50'd0, amt, imm_flag, OP_SHIFT};
		return w;
	endfunction

	function automatic instruction_t pfx_word(opcode_e op, logic sw, logic [55:0] v);
		instruction_t w;
		w.raw = {v, sw, op};
		return w;
	endfunction

	// Flag vectors are ordered a, b, c from the top bit down
	function automatic imm_rec_t mk_rec(value_t a, value_t b, value_t c,
			logic [2:0] has, logic [2:0] pfx);
		imm_rec_t r;
		r.imma     = a;
		r.immb     = b;
		r.immc     = c;
		r.has_imma = has[2];
		r.has_immb = has[1];
		r.has_immc = has[0];
		r.pfxa     = pfx[2];
		r.pfxb     = pfx[1];
		r.pfxc     = pfx[0];
		return r;
	endfunction

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic string run_name(int r);
		case (r)
		0: return "integer immediates";
		1: return "branch and shift";
		2: return "float immediates";
		3: return "prefix merging";
		4: return "stream under back-pressure";
		5: return "run ending in a prefix";
		default: return "prefix cleared by start";
		endcase
	endfunction

	task automatic add_rec(instruction_t w, imm_rec_t e);
		tbl[n_tbl].word   = w;
		tbl[n_tbl].is_rec = 1'b1;
		tbl[n_tbl].exp    = e;
		n_tbl++;
	endtask

	task automatic add_pfx(instruction_t w);
		tbl[n_tbl].word   = w;
		tbl[n_tbl].is_rec = 1'b0;
		tbl[n_tbl].exp    = '0;
		n_tbl++;
	endtask

	// ======================================================================
	// Stimulus table
	// ======================================================================

	task automatic build_table();
		n_tbl = 0;
		// Rows 0 to 5, integer and memory immediates in b
		add_rec(imm_word(OP_ADDI, 32'h8000_0010),
			mk_rec(0, 64'hffff_ffff_8000_0010, 0, 3'b010, 3'b000));
		add_rec(imm_word(OP_ADDI, 32'h0000_1234), mk_rec(0, 64'h1234, 0, 3'b010, 3'b000));
		add_rec(imm_word(OP_ANDI, 32'h0000_00f0),
			mk_rec(0, 64'hffff_ffff_0000_00f0, 0, 3'b010, 3'b000));
		add_rec(imm_word(OP_ORI, 32'hf000_0001),
			mk_rec(0, 64'h0000_0000_f000_0001, 0, 3'b010, 3'b000));
		add_rec(ls_word(OP_LDX, 24'h80_0004),
			mk_rec(0, 64'hffff_ffff_ff80_0004, 0, 3'b010, 3'b000));
		add_rec(ls_word(OP_STX, 24'h00_0100), mk_rec(0, 64'h100, 0, 3'b010, 3'b000));
		// Rows 6 to 9, branch and shift in c
		add_rec(br_word(20'h8_0001), mk_rec(0, 0, 64'hffff_ffff_fff8_0001, 3'b001, 3'b000));
		add_rec(br_word(20'h0_0010), mk_rec(0, 0, 64'h10, 3'b001, 3'b000));
		add_rec(sh_word(6'h2a, 1'b1), mk_rec(0, 0, 64'h2a, 3'b001, 3'b000));
		add_rec(sh_word(6'h15, 1'b0), mk_rec(0, 0, 64'h15, 3'b000, 3'b000));
		// Rows 10 to 16, 1.0, -2.5, pi, zero, infinity, NaN and a negative denormal
		add_rec(imm_word(OP_FADDI, 32'h3f80_0000),
			mk_rec(0, 64'h3ff0_0000_0000_0000, 0, 3'b010, 3'b000));
		add_rec(imm_word(OP_FADDI, 32'hc020_0000),
			mk_rec(0, 64'hc004_0000_0000_0000, 0, 3'b010, 3'b000));
		add_rec(imm_word(OP_FADDI, 32'h4049_0fdb),
			mk_rec(0, 64'h4009_21fb_6000_0000, 0, 3'b010, 3'b000));
		add_rec(imm_word(OP_FADDI, 32'h0000_0000), mk_rec(0, 0, 0, 3'b010, 3'b000));
		add_rec(imm_word(OP_FADDI, 32'h7f80_0000),
			mk_rec(0, 64'h7ff0_0000_0000_0000, 0, 3'b010, 3'b000));
		add_rec(imm_word(OP_FADDI, 32'h7fc0_0001),
			mk_rec(0, 64'h7ff8_0000_2000_0000, 0, 3'b010, 3'b000));
		add_rec(imm_word(OP_FADDI, 32'h8000_0001),
			mk_rec(0, 64'h8000_0000_0000_0000, 0, 3'b010, 3'b000));
		// Rows 17 to 24, prefixes into a, b and twice into c, then a clean ANDI
		add_pfx(pfx_word(OP_PFXAB, 1'b0, 56'h12_3456_789a_bcde));
		add_rec(imm_word(OP_ADDI, 32'h0000_0055),
			mk_rec(64'h1234_5678_9abc_de00, 64'h55, 0, 3'b110, 3'b100));
		add_pfx(pfx_word(OP_PFXAB, 1'b1, 56'h00_0000_0000_0001));
		add_rec(imm_word(OP_ORI, 32'haabb_ccdd),
			mk_rec(0, 64'h0000_0000_0000_01dd, 0, 3'b010, 3'b010));
		add_pfx(pfx_word(OP_PFXC, 1'b0, 56'h11_1111_1111_1111));
		add_pfx(pfx_word(OP_PFXC, 1'b0, 56'h22_2222_2222_2222));
		add_rec(br_word(20'hf_ffff), mk_rec(0, 0, 64'h2222_2222_2222_22ff, 3'b001, 3'b001));
		add_rec(imm_word(OP_ANDI, 32'h0000_000f),
			mk_rec(0, 64'hffff_ffff_0000_000f, 0, 3'b010, 3'b000));
		// Rows 25 to 27, the run ends on a prefix that must not leak into row 28
		add_rec(imm_word(OP_ADDI, 32'hffff_ffff),
			mk_rec(0, 64'hffff_ffff_ffff_ffff, 0, 3'b010, 3'b000));
		add_rec(imm_word(OP_NOP, 32'h0000_0000), mk_rec(0, 0, 0, 3'b000, 3'b000));
		add_pfx(pfx_word(OP_PFXAB, 1'b0, 56'h7f_ffff_ffff_ffff));
		add_rec(imm_word(OP_ADDI, 32'h0000_0001), mk_rec(0, 64'h1, 0, 3'b010, 3'b000));
	endtask

	// Unused locations hold NOP words tagged with their own index
	task automatic fill_memory();
		for (int i = 0; i < 64; i++)
			u_mem.mem[i] = {32'h5a5a_0000 ^ 32'(i), 32'(i) << 7};
		for (int i = 0; i < n_tbl; i++)
			u_mem.mem[i] = tbl[i].word.raw;
	endtask

	// ======================================================================
	// Checks
	// ======================================================================

	task automatic check_rec(int src, imm_rec_t got, imm_rec_t exp);
		rec_checks++;
		if (got !== exp)
		begin
			rec_errors++;
			$display("FAILED rec word %0d: imma %h immb %h immc %h flags %h",
				src, got.imma, got.immb, got.immc, got[5:0]);
			$display("FAILED rec word %0d: expected imma %h immb %h immc %h flags %h",
				src, exp.imma, exp.immb, exp.immc, exp[5:0]);
		end
	endtask

	task automatic check_done(int r, int pulses, int left);
		if (pulses != 1)
		begin
			run_errors++;
			$display("run %0d: done pulsed %0d times instead of once", r, pulses);
		end
		if (left != 0)
		begin
			run_errors++;
			$display("run %0d: done came while %0d records were still outstanding", r, left);
		end
	endtask

	// Stalls and ack delays change every cycle from the upper LCG bits
	always @(posedge clk)
	begin
		rnd = lcg_next();
		rec_ready <= (rnd[27:26] != 2'b00);
		ack_delay <= rnd[30:28];
	end

	// Sampled mid-cycle, a valid record is compared every cycle it is held
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (done)
			begin
				done_cnt++;
				left_at_done = exp_total - taken;
			end
			if (rec_valid)
			begin
				if (taken >= exp_total)
				begin
					rec_errors++;
					$display("record offered while none is outstanding");
				end
				else
				begin
					check_rec(exp_src[taken], rec, exp_list[taken]);
					if (rec_ready)
						taken++;
				end
			end
		end
	end

	// One read at a time, held until its ack, at consecutive word addresses
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (wb_stb && !wb_cyc)
			begin
				run_errors++;
				$display("wb_stb is high outside a bus cycle");
			end
			if (req_open && !(wb_cyc && wb_stb))
			begin
				run_errors++;
				$display("read request dropped before the slave acknowledged it");
			end
			if (wb_cyc && rec_valid)
			begin
				run_errors++;
				$display("a new read was issued while a record was still offered");
			end
			if (wb_cyc && wb_stb)
			begin
				if (wb_adr !== exp_adr)
				begin
					run_errors++;
					$display("FAILED wb_adr %h expected %h", wb_adr, exp_adr);
				end
				if (wb_ack)
					exp_adr = exp_adr + 32'd8;
			end
			req_open = wb_cyc && wb_stb && !wb_ack;
		end
	end

	// ======================================================================
	// Run control
	// ======================================================================

	task automatic run_test(int r);
		int first;
		int count;
		int d0;
		int e0;
		int waited;
		int limit;
		first  = run_first[r];
		count  = run_count[r];
		d0     = done_cnt;
		e0     = rec_errors + run_errors;
		limit  = count * word_cycles + run_margin;
		waited = 0;
		for (int i = first; i < first + count; i++)
		begin
			if (tbl[i].is_rec)
			begin
				exp_list[exp_total] = tbl[i].exp;
				exp_src[exp_total]  = i;
				exp_total++;
			end
		end
		left_at_done = exp_total - taken;
		exp_adr      = base_addr + 32'(first * 8);
		@(posedge clk);
		start      <= 1'b1;
		start_addr <= base_addr + 32'(first * 8);
		word_count <= 16'(count);
		@(posedge clk);
		start <= 1'b0;
		while (done_cnt == d0 && waited < limit)
		begin
			@(posedge clk);
			waited++;
		end
		if (done_cnt == d0)
		begin
			run_errors++;
			$display("run %0d: no done within %0d cycles", r, limit);
		end
		// A few idle cycles expose a second done pulse or a stray record
		repeat (4) @(posedge clk);
		check_done(r, done_cnt - d0, left_at_done);
		if (rec_errors + run_errors == e0)
		begin
			tests_passed++;
			$display("run %0d %0s: passed", r, run_name(r));
		end
		else
		begin
			tests_failed++;
			$display("run %0d %0s: failed", r, run_name(r));
		end
	endtask

	initial
	begin
		reset      = 1'b1;
		start      = 1'b0;
		start_addr = '0;
		word_count = '0;
		build_table();
		fill_memory();
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		for (int r = 0; r < n_runs; r++)
			run_test(r);
		$display("runs %0d, passed %0d, failed %0d, record checks %0d, errors %0d",
			n_runs, tests_passed, tests_failed, rec_checks, rec_errors + run_errors);
		if (tests_failed == 0 && rec_errors + run_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Budget of every run plus reset and some slack, in clock periods
	initial
	begin : watchdog
		int cycles;
		cycles = 16 + 200;
		for (int r = 0; r < n_runs; r++)
			cycles += run_count[r] * word_cycles + run_margin;
		#(cycles * 100);
		$display("watchdog expired after %0d cycles, the run did not finish", cycles);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- test/tb_imm_mem.sv
/*
 * Wishbone classic instruction memory model for the testbench
 * 64-bit word array, read only, with an acknowledge delay set per cycle
 */
`timescale 1ns/100ps

module tb_imm_mem
#(
	parameter int depth = 64
)
(
	input  logic        clk,
	input  logic        reset,
	input  logic        cyc,
	input  logic        stb,
	input  logic [31:0] adr,
	input  logic [2:0]  delay,
	output logic [63:0] dat,
	output logic        ack
);

	localparam int idx_bits = $clog2(depth);

	// Filled by the testbench before reset is released
	logic [63:0] mem [depth];

	logic [3:0]  wait_cnt;
	logic [idx_bits-1:0] idx;

	// Byte address to word index, the low three bits select a byte
	assign idx = adr[3 +: idx_bits];

	// The wait counter runs while a request is open and the ack comes once it reaches delay
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack      <= 1'b0;
			dat      <= '0;
			wait_cnt <= '0;
		end
		else
		begin
			ack <= 1'b0;
			if (cyc && stb && !ack)
			begin
				if (wait_cnt >= {1'b0, delay})
				begin
					ack      <= 1'b1;
					dat      <= mem[idx];
					wait_cnt <= '0;
				end
				else
					wait_cnt <= wait_cnt + 4'd1;
			end
		end
	end

endmodule
